//--- hw/amo_types_pkg.sv
//////////////////////////////////////////////////
// Operation encodings for the atomic subsystem
// AMO operation codes and request kinds
// SC result words returned to the agents
//////////////////////////////////////////////////

package amo_types_pkg;

    //////////////////////////////////////////////////
    // AMO operation codes
    typedef enum logic [3:0] {
        // Arithmetic and swap
        AMO_ADD  = 4'd0,
        AMO_SWAP = 4'd1,
        // Bitwise
        AMO_XOR  = 4'd2,
        AMO_AND  = 4'd3,
        AMO_OR   = 4'd4,
        // Signed compare
        AMO_MIN  = 4'd5,
        AMO_MAX  = 4'd6,
        // Unsigned compare
        AMO_MINU = 4'd7,
        AMO_MAXU = 4'd8
    } amo_t;

    //////////////////////////////////////////////////
    // Request kinds issued by an agent
    typedef enum logic [1:0] {
        // Load-reserved
        REQ_LR  = 2'd0,
        // Store-conditional
        REQ_SC  = 2'd1,
        // Read-modify-write through the ALU
        REQ_RMW = 2'd2
    } req_kind_t;

    // Store-conditional result words
    localparam logic [31:0] SC_SUCCESS = 32'd0;
    localparam logic [31:0] SC_FAIL    = 32'd1;

endpackage

//--- hw/amo_cfg_pkg.sv
//////////////////////////////////////////////////
// Sizing of the atomic subsystem
// Agent count, word and address widths
// Scratch memory depth and reservation granule
//////////////////////////////////////////////////

package amo_cfg_pkg;

    // Requesters sharing the memory
    localparam int NUM_AGENTS = 3;
    localparam int AGENT_ID_W = 2;

    // Word and byte address widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    // Scratch memory in words
    localparam int MEM_WORDS = 64;
    localparam int MEM_IDX_W = 6;

    // Reservation covers an aligned group of words
    localparam int RESERVATION_WORDS = 4;

endpackage

//--- hw/amo_alu.sv
//////////////////////////////////////////////////
// Combinational RISC-V atomic ALU
// Add, swap, bitwise and min/max on two words
//////////////////////////////////////////////////

`timescale 1ns/10ps

module amo_alu
    import amo_types_pkg::*;
    import amo_cfg_pkg::*;
#(
    parameter int WIDTH = DATA_W
) (
    input  amo_t             amo_type,
    input  logic [WIDTH-1:0] rs1,
    input  logic [WIDTH-1:0] rs2,
    output logic [WIDTH-1:0] rd
);

    logic rs1_lt_signed;
    logic rs1_lt_unsigned;

    // Shared comparators for the min/max family
    assign rs1_lt_signed = ($signed(rs1) < $signed(rs2));
    assign rs1_lt_unsigned = (rs1 < rs2);

    always_comb begin
        case (amo_type)
            AMO_ADD:  rd = rs1 + rs2;
            AMO_SWAP: rd = rs2;
            AMO_XOR:  rd = rs1 ^ rs2;
            AMO_AND:  rd = rs1 & rs2;
            AMO_OR:   rd = rs1 | rs2;
            AMO_MIN:  rd = rs1_lt_signed ? rs1 : rs2;
            AMO_MAX:  rd = rs1_lt_signed ? rs2 : rs1;
            AMO_MINU: rd = rs1_lt_unsigned ? rs1 : rs2;
            AMO_MAXU: rd = rs1_lt_unsigned ? rs2 : rs1;
            // Unknown codes leave memory unchanged
            default:  rd = rs1;
        endcase
    end

endmodule

//--- hw/amo_unit.sv
//////////////////////////////////////////////////
// Shared atomic unit
// Single LR/SC reservation for all agents
// Operand multiplexing onto one atomic ALU
//////////////////////////////////////////////////

`timescale 1ns/10ps

module amo_unit
    import amo_types_pkg::*;
    import amo_cfg_pkg::*;
#(
    parameter int NUM_UNITS = NUM_AGENTS,
    parameter int RESERVATION_WORDS = amo_cfg_pkg::RESERVATION_WORDS
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic     [NUM_UNITS-1:0]              set_reservation,
    input  logic     [NUM_UNITS-1:0]              clear_reservation,
    input  logic     [NUM_UNITS-1:0][ADDR_W-1:0]  reservation,
    input  logic     [NUM_UNITS-1:0]              rmw_valid,
    input  amo_t     [NUM_UNITS-1:0]              op,
    input  logic     [NUM_UNITS-1:0][DATA_W-1:0]  rs1,
    input  logic     [NUM_UNITS-1:0][DATA_W-1:0]  rs2,
    output logic     [NUM_UNITS-1:0]              reservation_valid,
    output logic     [DATA_W-1:0]                 rd
);

    // Granule tag drops the byte and in-granule word bits
    localparam int RES_W = ADDR_W - 2 - $clog2(RESERVATION_WORDS);

    logic [RES_W-1:0]  lr_addr;
    logic              lr_valid;
    logic [RES_W-1:0]  set_val;
    amo_t              selected_op;
    logic [DATA_W-1:0] selected_rs1;
    logic [DATA_W-1:0] selected_rs2;

    // Each agent sees a match against its own granule
    for (genvar i = 0; i < NUM_UNITS; i++) begin : gen_match
        assign reservation_valid[i] = lr_valid && (lr_addr == reservation[i][ADDR_W-1 -: RES_W]);
    end

    //////////////////////////////////////////////////
    // Select the active agent's inputs
    always_comb begin
        set_val = '0;
        selected_op = AMO_ADD;
        selected_rs1 = '0;
        selected_rs2 = '0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (set_reservation[i]) begin
                set_val = reservation[i][ADDR_W-1 -: RES_W];
            end
            if (rmw_valid[i]) begin
                selected_op = op[i];
                selected_rs1 = rs1[i];
                selected_rs2 = rs2[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Reservation register
    // Set beats clear when both arrive together
    always_ff @(posedge clk) begin
        if (rst) begin
            lr_valid <= 1'b0;
        end else begin
            lr_valid <= (lr_valid && !(|clear_reservation)) || (|set_reservation);
        end
        if (|set_reservation) begin
            lr_addr <= set_val;
        end
    end

    // Combinational result in the operand cycle
    amo_alu #(
        .WIDTH(DATA_W)
    ) alu_inst (
        .amo_type(selected_op),
        .rs1(selected_rs1),
        .rs2(selected_rs2),
        .rd(rd)
    );

    // Only one agent may drive each shared path
    set_onehot_a : assert property (@(posedge clk) disable iff (rst)
        $onehot0(set_reservation));
    rmw_onehot_a : assert property (@(posedge clk) disable iff (rst)
        $onehot0(rmw_valid));

endmodule

//--- hw/amo_arbiter_stage.sv
//////////////////////////////////////////////////
// Round-robin arbiter stage
// Combinational grant from requests and pointer
// First pipeline register holding the winner
//////////////////////////////////////////////////

`timescale 1ns/10ps

module amo_arbiter_stage
    import amo_types_pkg::*;
    import amo_cfg_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic      [NUM_AGENTS-1:0]          req,
    input  req_kind_t [NUM_AGENTS-1:0]          req_kind,
    input  amo_t      [NUM_AGENTS-1:0]          req_op,
    input  logic      [NUM_AGENTS-1:0][ADDR_W-1:0] req_addr,
    input  logic      [NUM_AGENTS-1:0][DATA_W-1:0] req_data,
    output logic      [NUM_AGENTS-1:0]          grant,
    output logic                                s1_valid,
    output logic      [AGENT_ID_W-1:0]          s1_agent,
    output req_kind_t                           s1_kind,
    output amo_t                                s1_op,
    output logic      [ADDR_W-1:0]              s1_addr,
    output logic      [DATA_W-1:0]              s1_data
);

    // Agent where the next search begins
    logic [AGENT_ID_W-1:0] rr_ptr;
    logic                  found;
    logic [AGENT_ID_W-1:0] winner;

    //////////////////////////////////////////////////
    // Winner selection
    always_comb begin
        int idx;
        found = 1'b0;
        winner = '0;
        // Walk the agents starting at the pointer, wrapping around
        for (int i = 0; i < NUM_AGENTS; i++) begin
            idx = (int'(rr_ptr) + i) % NUM_AGENTS;
            if (!found && req[idx]) begin
                found = 1'b1;
                winner = AGENT_ID_W'(idx);
            end
        end
        grant = found ? (NUM_AGENTS'(1) << winner) : '0;
    end

    //////////////////////////////////////////////////
    // Pointer and stage 1 register
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= found;
            // Next search starts just past the winner
            if (found) begin
                if (winner == AGENT_ID_W'(NUM_AGENTS - 1)) begin
                    rr_ptr <= '0;
                end else begin
                    rr_ptr <= winner + AGENT_ID_W'(1);
                end
            end
        end
        // Capture the granted agent's fields
        if (found) begin
            s1_agent <= winner;
            s1_kind <= req_kind[winner];
            s1_op <= req_op[winner];
            s1_addr <= req_addr[winner];
            s1_data <= req_data[winner];
        end
    end

    // At most one agent granted per cycle
    grant_onehot_a : assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant));

endmodule

//--- hw/amo_mem_stage.sv
//////////////////////////////////////////////////
// Memory stage of the atomic pipeline
// Scratch memory with write forwarding
// Stage 2 register and one-hot agent strobes
// Write-back and response register
//////////////////////////////////////////////////

`timescale 1ns/10ps

module amo_mem_stage
    import amo_types_pkg::*;
    import amo_cfg_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   s1_valid,
    input  logic      [AGENT_ID_W-1:0]             s1_agent,
    input  req_kind_t                              s1_kind,
    input  amo_t                                   s1_op,
    input  logic      [ADDR_W-1:0]                 s1_addr,
    input  logic      [DATA_W-1:0]                 s1_data,
    input  logic      [NUM_AGENTS-1:0]             reservation_valid,
    input  logic      [DATA_W-1:0]                 rd,
    output logic      [NUM_AGENTS-1:0]             set_reservation,
    output logic      [NUM_AGENTS-1:0]             clear_reservation,
    output logic      [NUM_AGENTS-1:0][ADDR_W-1:0] reservation,
    output logic      [NUM_AGENTS-1:0]             rmw_valid,
    output amo_t      [NUM_AGENTS-1:0]             op,
    output logic      [NUM_AGENTS-1:0][DATA_W-1:0] rs1,
    output logic      [NUM_AGENTS-1:0][DATA_W-1:0] rs2,
    output logic      [NUM_AGENTS-1:0]             resp_valid,
    output logic      [DATA_W-1:0]                 resp_data
);

    logic [DATA_W-1:0] mem [MEM_WORDS];

    // Stage 2 operation
    logic                  s2_valid;
    logic [AGENT_ID_W-1:0] s2_agent;
    req_kind_t             s2_kind;
    amo_t                  s2_op;
    logic [ADDR_W-1:0]     s2_addr;
    logic [DATA_W-1:0]     s2_data;
    logic [DATA_W-1:0]     s2_word;

    logic [MEM_IDX_W-1:0]  s1_idx;
    logic [MEM_IDX_W-1:0]  s2_idx;
    logic [DATA_W-1:0]     rd_word;
    logic [NUM_AGENTS-1:0] agent_oh;
    logic                  is_lr;
    logic                  is_sc;
    logic                  is_rmw;
    logic                  sc_ok;
    logic                  wr_en;
    logic [DATA_W-1:0]     wr_data;
    logic [DATA_W-1:0]     resp_word;

    // Word index from the byte address
    assign s1_idx = s1_addr[MEM_IDX_W+1:2];
    assign s2_idx = s2_addr[MEM_IDX_W+1:2];

    //////////////////////////////////////////////////
    // Read with forwarding of the write in flight
    assign rd_word = (wr_en && (s2_idx == s1_idx)) ? wr_data : mem[s1_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
        s2_agent <= s1_agent;
        s2_kind <= s1_kind;
        s2_op <= s1_op;
        s2_addr <= s1_addr;
        s2_data <= s1_data;
        s2_word <= rd_word;
    end

    //////////////////////////////////////////////////
    // Agent decode into strobes for the atomic unit
    assign agent_oh = s2_valid ? (NUM_AGENTS'(1) << s2_agent) : '0;
    assign is_lr = (s2_kind == REQ_LR);
    assign is_sc = (s2_kind == REQ_SC);
    assign is_rmw = (s2_kind == REQ_RMW);

    assign set_reservation = agent_oh & {NUM_AGENTS{is_lr}};
    // Both SC and RMW drop the shared reservation
    assign clear_reservation = agent_oh & {NUM_AGENTS{is_sc | is_rmw}};
    assign rmw_valid = agent_oh & {NUM_AGENTS{is_rmw}};

    // Only the decoded agent's lane carries the stage 2 operation
    for (genvar i = 0; i < NUM_AGENTS; i++) begin : gen_lanes
        assign reservation[i] = agent_oh[i] ? s2_addr : '0;
        assign op[i] = agent_oh[i] ? s2_op : AMO_ADD;
        assign rs1[i] = agent_oh[i] ? s2_word : '0;
        assign rs2[i] = agent_oh[i] ? s2_data : '0;
    end

    //////////////////////////////////////////////////
    // Write-back and response
    assign sc_ok = reservation_valid[s2_agent];
    assign wr_en = s2_valid && (is_rmw || (is_sc && sc_ok));
    assign wr_data = is_rmw ? rd : s2_data;
    // SC reports its status while LR and RMW return the old word
    assign resp_word = is_sc ? (sc_ok ? SC_SUCCESS : SC_FAIL) : s2_word;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[s2_idx] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= '0;
        end else begin
            resp_valid <= agent_oh;
        end
        resp_data <= resp_word;
    end

    // Arbiter only ever issues existing agents
    s2_agent_range_a : assert property (@(posedge clk) disable iff (rst)
        s2_valid |-> (s2_agent < AGENT_ID_W'(NUM_AGENTS)));

endmodule

//--- hw/atomic_subsystem.sv
//////////////////////////////////////////////////
// Top level of the shared atomic subsystem
// Arbiter stage, memory stage and atomic unit
//////////////////////////////////////////////////

`timescale 1ns/10ps

module atomic_subsystem
    import amo_types_pkg::*;
    import amo_cfg_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic      [NUM_AGENTS-1:0]             req,
    input  req_kind_t [NUM_AGENTS-1:0]             req_kind,
    input  amo_t      [NUM_AGENTS-1:0]             req_op,
    input  logic      [NUM_AGENTS-1:0][ADDR_W-1:0] req_addr,
    input  logic      [NUM_AGENTS-1:0][DATA_W-1:0] req_data,
    output logic      [NUM_AGENTS-1:0]             grant,
    output logic      [NUM_AGENTS-1:0]             resp_valid,
    output logic      [DATA_W-1:0]                 resp_data
);

    // Arbiter to memory stage
    logic                  s1_valid;
    logic [AGENT_ID_W-1:0] s1_agent;
    req_kind_t             s1_kind;
    amo_t                  s1_op;
    logic [ADDR_W-1:0]     s1_addr;
    logic [DATA_W-1:0]     s1_data;

    // Memory stage to atomic unit and back
    logic [NUM_AGENTS-1:0]             set_reservation;
    logic [NUM_AGENTS-1:0]             clear_reservation;
    logic [NUM_AGENTS-1:0][ADDR_W-1:0] reservation;
    logic [NUM_AGENTS-1:0]             rmw_valid;
    amo_t [NUM_AGENTS-1:0]             op;
    logic [NUM_AGENTS-1:0][DATA_W-1:0] rs1;
    logic [NUM_AGENTS-1:0][DATA_W-1:0] rs2;
    logic [NUM_AGENTS-1:0]             reservation_valid;
    logic [DATA_W-1:0]                 rd;

    amo_arbiter_stage arbiter_inst (
        .clk, .rst,
        .req, .req_kind, .req_op, .req_addr, .req_data,
        .grant,
        .s1_valid, .s1_agent, .s1_kind, .s1_op, .s1_addr, .s1_data
    );

    amo_mem_stage mem_stage_inst (
        .clk, .rst,
        .s1_valid, .s1_agent, .s1_kind, .s1_op, .s1_addr, .s1_data,
        .reservation_valid, .rd,
        .set_reservation, .clear_reservation, .reservation,
        .rmw_valid, .op, .rs1, .rs2,
        .resp_valid, .resp_data
    );

    amo_unit #(
        .NUM_UNITS(NUM_AGENTS),
        .RESERVATION_WORDS(RESERVATION_WORDS)
    ) amo_unit_inst (
        .clk, .rst,
        .set_reservation, .clear_reservation, .reservation,
        .rmw_valid, .op, .rs1, .rs2,
        .reservation_valid, .rd
    );

endmodule

//--- verification/tb_atomic_subsystem.sv
//////////////////////////////////////////////////
// Testbench for the shared atomic subsystem
// Clock, reset and pattern-file driven agents
// Round-robin model for the expected grant order
// Response monitor with latency and data checks
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_atomic_subsystem
    import amo_types_pkg::*;
    import amo_cfg_pkg::*;
();

    localparam int HALF_PERIOD = 10;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 4;
    // Response strobe three cycles after the grant cycle
    localparam int RESP_LAT = 3;
    localparam int GRANT_TIMEOUT = 16;
    localparam int DRAIN_TIMEOUT = 32;
    localparam int LINE_CHARS = 200;

    logic                              clk = 1'b0;
    logic                              rst = 1'b1;
    logic [NUM_AGENTS-1:0]             req;
    req_kind_t [NUM_AGENTS-1:0]        req_kind;
    amo_t [NUM_AGENTS-1:0]             req_op;
    logic [NUM_AGENTS-1:0][ADDR_W-1:0] req_addr;
    logic [NUM_AGENTS-1:0][DATA_W-1:0] req_data;
    logic [NUM_AGENTS-1:0]             grant;
    logic [NUM_AGENTS-1:0]             resp_valid;
    logic [DATA_W-1:0]                 resp_data;

    int cycle_count = 0;
    int check_count = 0;
    int err_count = 0;
    int fail_count = 0;
    bit aborted = 1'b0;
    // Model of the arbiter pointer
    int rr_ptr = 0;

    // Pattern reader with one line of lookahead
    int                      fd;
    logic [8*LINE_CHARS-1:0] line_buf;
    bit                      have_next;
    string                   nx_name;
    int                      nx_group;
    logic [31:0]             nx_mask;
    int                      nx_kind;
    int                      nx_op;
    logic [31:0]             nx_addr;
    logic [31:0]             nx_data;
    int                      nx_chk;
    logic [31:0]             nx_exp;

    // One request slot per agent
    string       slot_name [NUM_AGENTS];
    int          slot_kind [NUM_AGENTS];
    int          slot_op   [NUM_AGENTS];
    logic [31:0] slot_addr [NUM_AGENTS];
    logic [31:0] slot_data [NUM_AGENTS];
    int          slot_chk  [NUM_AGENTS];
    logic [31:0] slot_exp  [NUM_AGENTS];

    // Expected responses in grant order
    int          exp_agent_q [$];
    int          exp_cycle_q [$];
    int          exp_chk_q   [$];
    logic [31:0] exp_data_q  [$];
    string       exp_name_q  [$];

    atomic_subsystem uut (
        .clk, .rst,
        .req, .req_kind, .req_op, .req_addr, .req_data,
        .grant, .resp_valid, .resp_data
    );

    always #(HALF_PERIOD) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    //////////////////////////////////////////////////
    // Helpers
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic next_drive_slot();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    function automatic int first_agent(input logic [NUM_AGENTS-1:0] vec);
        int pick;
        pick = -1;
        for (int i = NUM_AGENTS - 1; i >= 0; i--) begin
            if (vec[i] === 1'b1) pick = i;
        end
        return pick;
    endfunction

    // Winner is the first requester at or after the pointer
    function automatic int pick_round_robin(input logic [NUM_AGENTS-1:0] pending, input int ptr);
        int idx;
        int pick;
        pick = -1;
        for (int i = 0; i < NUM_AGENTS; i++) begin
            idx = (ptr + i) % NUM_AGENTS;
            if (pick < 0 && pending[idx]) pick = idx;
        end
        return pick;
    endfunction

    function automatic int agent_of_mask(input logic [31:0] mask);
        case (mask)
            32'h1: return 0;
            32'h2: return 1;
            32'h4: return 2;
            default: return -1;
        endcase
    endfunction

    task automatic drop_expected();
        void'(exp_agent_q.pop_front());
        void'(exp_cycle_q.pop_front());
        void'(exp_chk_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_name_q.pop_front());
    endtask

    //////////////////////////////////////////////////
    // Pattern file
    // Comment and blank lines do not scan to nine fields
    task automatic read_next();
        int n;
        bit done;
        have_next = 1'b0;
        done = 1'b0;
        while (!done) begin
            line_buf = '0;
            if ($fgets(line_buf, fd) == 0) begin
                done = 1'b1;
            end else begin
                n = $sscanf(line_buf, "%s %d %h %d %d %h %h %d %h", nx_name, nx_group,
                            nx_mask, nx_kind, nx_op, nx_addr, nx_data, nx_chk, nx_exp);
                if (n == 9) begin
                    have_next = 1'b1;
                    done = 1'b1;
                end
            end
        end
    endtask

    // Lines sharing a group number request together
    task automatic load_group(output logic [NUM_AGENTS-1:0] pend);
        int grp;
        int a;
        pend = '0;
        grp = nx_group;
        while (have_next && nx_group == grp) begin
            a = agent_of_mask(nx_mask);
            if (a < 0 || pend[a]) begin
                fail_count++;
                $display("Pattern %s has a bad or repeated agent mask %h", nx_name, nx_mask);
            end else begin
                pend[a] = 1'b1;
                slot_name[a] = nx_name;
                slot_kind[a] = nx_kind;
                slot_op[a] = nx_op;
                slot_addr[a] = nx_addr;
                slot_data[a] = nx_data;
                slot_chk[a] = nx_chk;
                slot_exp[a] = nx_exp;
            end
            read_next();
        end
    endtask

    //////////////////////////////////////////////////
    // Agent driver
    task automatic issue_group(input logic [NUM_AGENTS-1:0] pend_in);
        logic [NUM_AGENTS-1:0] pend;
        int waited;
        int expect_a;
        int got_a;
        pend = pend_in;
        waited = 0;
        for (int a = 0; a < NUM_AGENTS; a++) begin
            if (pend[a]) begin
                req_kind[a] = req_kind_t'(slot_kind[a]);
                req_op[a] = amo_t'(slot_op[a]);
                req_addr[a] = slot_addr[a];
                req_data[a] = slot_data[a];
            end
        end
        req = pend;
        while (pend != '0 && !aborted) begin
            @(negedge clk);
            if (grant !== '0) begin
                expect_a = pick_round_robin(pend, rr_ptr);
                got_a = first_agent(grant);
                check_value({slot_name[expect_a], "_grant"}, 32'(1) << expect_a, grant);
                if (got_a >= 0 && pend[got_a]) begin
                    exp_agent_q.push_back(got_a);
                    exp_cycle_q.push_back(cycle_count + RESP_LAT);
                    exp_chk_q.push_back(slot_chk[got_a]);
                    exp_data_q.push_back(slot_exp[got_a]);
                    exp_name_q.push_back(slot_name[got_a]);
                    pend[got_a] = 1'b0;
                    rr_ptr = (got_a + 1) % NUM_AGENTS;
                    waited = 0;
                end else begin
                    fail_count++;
                    aborted = 1'b1;
                    $display("Grant %b went to an agent without a request", grant);
                end
            end else begin
                waited++;
                if (waited >= GRANT_TIMEOUT) begin
                    fail_count++;
                    aborted = 1'b1;
                    $display("Timed out waiting for a grant at cycle %0d", cycle_count);
                end
            end
            // Granted agents drop the request after the capture edge
            next_drive_slot();
            req = pend;
        end
    endtask

    //////////////////////////////////////////////////
    // Response monitor
    always @(negedge clk) begin
        if (!rst && resp_valid !== '0) begin
            if (exp_agent_q.size() == 0) begin
                fail_count++;
                $display("Response strobe %b at cycle %0d with nothing in flight",
                         resp_valid, cycle_count);
            end else begin
                check_value({exp_name_q[0], "_agent"}, 32'(1) << exp_agent_q[0], resp_valid);
                check_value({exp_name_q[0], "_cycle"}, exp_cycle_q[0], cycle_count);
                if (exp_chk_q[0] != 0) begin
                    check_value(exp_name_q[0], exp_data_q[0], resp_data);
                end
                drop_expected();
            end
        end else if (!rst && exp_cycle_q.size() > 0 && exp_cycle_q[0] < cycle_count) begin
            fail_count++;
            $display("No response for %s by cycle %0d", exp_name_q[0], exp_cycle_q[0]);
            drop_expected();
        end
    end

    task automatic finish_run();
        $display("Summary %0d checks, %0d mismatches, %0d other failures",
                 check_count, err_count, fail_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    initial begin
        int gap;
        int waited;
        logic [NUM_AGENTS-1:0] pend;
        gap = $urandom(16);
        req = '0;
        for (int a = 0; a < NUM_AGENTS; a++) begin
            req_kind[a] = REQ_LR;
            req_op[a] = AMO_ADD;
            req_addr[a] = '0;
            req_data[a] = '0;
        end
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        // Idle outputs straight after reset
        @(negedge clk);
        check_value("reset_grant", '0, grant);
        check_value("reset_resp_valid", '0, resp_valid);
        fd = $fopen("verification/atomic_patterns.txt", "r");
        if (fd == 0) begin
            fail_count++;
            $display("Cannot open the pattern file");
        end else begin
            read_next();
            next_drive_slot();
            while (have_next && !aborted) begin
                load_group(pend);
                issue_group(pend);
                gap = $urandom % 4;
                repeat (gap) next_drive_slot();
            end
            $fclose(fd);
            // Last responses still in the pipeline
            waited = 0;
            while (exp_agent_q.size() > 0 && !aborted) begin
                @(negedge clk);
                waited++;
                if (waited >= DRAIN_TIMEOUT) begin
                    fail_count++;
                    aborted = 1'b1;
                    $display("Timed out waiting for the last responses");
                end
            end
        end
        finish_run();
    end

endmodule

//--- all.f
hw/amo_types_pkg.sv
hw/amo_cfg_pkg.sv
hw/amo_alu.sv
hw/amo_unit.sv
hw/amo_arbiter_stage.sv
hw/amo_mem_stage.sv
hw/atomic_subsystem.sv
verification/tb_atomic_subsystem.sv

//--- Bender.yml
package:
  name: atomic_subsystem

sources:
  - hw/amo_types_pkg.sv
  - hw/amo_cfg_pkg.sv
  - hw/amo_alu.sv
  - hw/amo_unit.sv
  - hw/amo_arbiter_stage.sv
  - hw/amo_mem_stage.sv
  - hw/atomic_subsystem.sv
  - target: test
    files:
      - verification/tb_atomic_subsystem.sv

//--- verification/atomic_patterns.txt
# name group agent_mask kind op addr data check expected (hex: mask addr data expected)
# kind 0=lr 1=sc 2=rmw; op 0=add 1=swap 2=xor 3=and 4=or 5=min 6=max 7=minu 8=maxu; check 0 skips data
sc_no_lr      1 1 1 0 00000040 11111111 1 00000001
init_w10      2 2 2 1 00000010 00000064 0 00000000
amo_add       3 4 2 0 00000010 0000000a 1 00000064
add_result    4 1 2 1 00000010 0f0f00ff 1 0000006e
amo_xor       5 2 2 2 00000010 00ff00ff 1 0f0f00ff
xor_result    6 4 2 1 00000010 f0f0f0f0 1 0ff00000
amo_and       7 1 2 3 00000010 ff00ff00 1 f0f0f0f0
and_result    8 2 2 1 00000010 0000ffff 1 f000f000
amo_or        9 4 2 4 00000010 12340000 1 0000ffff
or_result    10 1 2 1 00000010 fffffff0 1 1234ffff
amo_min      11 2 2 5 00000010 ffffff00 1 fffffff0
min_result   12 4 2 1 00000010 00000005 1 ffffff00
amo_max      13 1 2 6 00000010 ffffffff 1 00000005
max_result   14 2 2 1 00000010 00000007 1 00000005
amo_minu     15 4 2 7 00000010 80000000 1 00000007
minu_result  16 1 2 1 00000010 80000000 1 00000007
amo_maxu     17 2 2 8 00000010 7fffffff 1 80000000
maxu_result  18 4 2 1 00000010 00000001 1 80000000
init_w20     19 1 2 1 00000020 00000aaa 0 00000000
lr_w20       20 1 0 0 00000020 00000000 1 00000aaa
sc_w20       21 1 1 0 00000020 00000bbb 1 00000000
sc_again     22 1 1 0 00000020 00000ccc 1 00000001
lr_w20_again 23 1 0 0 00000020 00000000 1 00000bbb
sc_w24       24 1 1 0 00000024 00000ddd 1 00000000
lr_w24       25 2 0 0 00000024 00000000 1 00000ddd
rmw_clears   26 4 2 0 00000010 00000001 1 00000001
sc_after_rmw 27 2 1 0 00000024 00000eee 1 00000001
lr_w24_again 28 2 0 0 00000024 00000000 1 00000ddd
sc_w28_other 29 4 1 0 00000028 12345678 1 00000000
sc_after_sc  30 2 1 0 00000024 00000eee 1 00000001
lr_w20_a0    31 1 0 0 00000020 00000000 1 00000bbb
lr_w10_a2    32 4 0 0 00000010 00000000 1 00000002
sc_granule   33 1 1 0 00000020 00000fff 1 00000001
w28_stored   34 2 0 0 00000028 00000000 1 12345678
w24_kept     35 4 0 0 00000024 00000000 1 00000ddd
w20_kept     36 1 0 0 00000020 00000000 1 00000bbb
init_w40     37 1 2 1 00000040 40404040 0 00000000
init_w44     37 2 2 1 00000044 44444444 0 00000000
init_w48     37 4 2 1 00000048 48484848 0 00000000
lr_w40_a1    38 2 0 0 00000040 00000000 1 40404040
rr_lr_w44    39 1 0 0 00000044 00000000 1 44444444
rr_lr_w48    39 2 0 0 00000048 00000000 1 48484848
rr_lr_w40    39 4 0 0 00000040 00000000 1 40404040
init_w50     40 1 2 1 00000050 00000064 0 00000000
fwd_add_a1   41 2 2 0 00000050 00000005 1 00000064
fwd_add_a2   41 4 2 0 00000050 00000007 1 00000069
fwd_xor_a0   42 1 2 2 00000050 000000ff 1 00000070
fwd_swap_a1  42 2 2 1 00000050 00001234 1 0000008f
fwd_or_a2    42 4 2 4 00000050 00010000 1 00001234
fwd_result   43 2 2 1 00000050 00000000 1 00011234
